//--- Bender.yml
package:
  name: cw_io

sources:
  - files:
      - cw_io_pkg.sv
      - cw_reg_file.sv
      - cw_trigger_route.sv
      - cw_target_io.sv
      - cw_power_ctrl.sv
      - cw_io_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_cw_io_top.sv

//--- all.f
+incdir+.
cw_io_pkg.sv
cw_reg_file.sv
cw_trigger_route.sv
cw_target_io.sv
cw_power_ctrl.sv
cw_io_top.sv
tb_cw_io_top.sv

//--- cw_io_pkg.sv
`default_nettype none

package cw_io_pkg;

   // Register bus widths
   typedef logic [7:0] reg_addr_t;
   typedef logic [7:0] reg_data_t;
   localparam int BYTECNT_W = 7;
   typedef logic [BYTECNT_W-1:0] bytecnt_t;

   // Register map
   localparam reg_addr_t ADDR_EXTCLK  = 8'h26;
   localparam reg_addr_t ADDR_TRIGSRC = 8'h27;
   localparam reg_addr_t ADDR_TRIGMOD = 8'h28;
   localparam reg_addr_t ADDR_IOROUTE = 8'h37;
   localparam reg_addr_t ADDR_IOREAD  = 8'h3B;

   localparam reg_data_t RST_EXTCLK  = 8'h03; // HS1 as clock source
   localparam reg_data_t RST_TRIGSRC = 8'h20; // IO4 enabled, OR mode
   localparam reg_data_t RST_TRIGMOD = 8'h00;
   localparam logic [63:0] RST_IOROUTE = 64'h0000_0000_0000_0201; // GPIO1 TX, GPIO2 RX

   localparam int IOROUTE_BYTES = 8;
   localparam int IOROUTE_IDX_W = $clog2(IOROUTE_BYTES);

   // Target pads
   localparam int NUM_PADS = 4;
   localparam int PAD_OC   = 2;     // GPIO3 has the open-collector modes

   // Soft start, short enough for simulation
   localparam int PWM_PERIOD_W   = 6;  // 64-cycle period
   localparam int PWM_OFF_CYCLES = 44;
   localparam int SOFT_STEPS     = 16;
   localparam int STEP_W         = $clog2(SOFT_STEPS + 1);

   typedef enum logic [1:0] {COMB_OR, COMB_AND, COMB_NAND, COMB_OFF} trig_combine_e;
   typedef enum logic [2:0] {TMOD_EDGE, TMOD_ADVIO, TMOD_SAD, TMOD_DECODED} trig_module_e;
   typedef enum logic [2:0] {EXT_AUX = 3'd0, EXT_HS1 = 3'd3} extclk_src_e;
   typedef enum logic [1:0] {PWR_OFF, PWR_RAMP, PWR_ON} power_state_e;

   typedef struct packed {
      logic        rsvd;
      logic        rear_en;         // Rear clock output on
      logic        rear_src_glitch; // 1 = glitch clock, 0 = PLL
      logic [1:0]  fp_mode;         // Front panel, stored only
      extclk_src_e extclk_sel;
   } clk_cfg_t;

   typedef struct packed {
      trig_combine_e combine;
      logic          en_io4;
      logic          en_io3;
      logic          en_io2;
      logic          en_io1;
      logic          en_nrst;
      logic          rsvd_src;   // Front panel line, not routed here
      logic [3:0]    rsvd_mod;
      logic          fp_out;
      trig_module_e  trig_mod;
   } trig_cfg_t;

   typedef struct packed {
      logic gpio_en;
      logic gpio_val;
      logic txo;   // Open-collector TX
      logic usoc;  // Open-collector USI out
      logic usii;
      logic usio;
      logic rx;
      logic tx;
   } gpio_cfg_t;

   typedef struct packed {
      logic [1:0] rsvd_pin;
      logic       pdic_val;
      logic       pdic_en;
      logic       pdid_val;
      logic       pdid_en;
      logic       nrst_val;
      logic       nrst_en;
      logic [4:0] rsvd_misc;
      logic       avr_en;
      logic       glitch_b;
      logic       glitch_a;
      gpio_cfg_t [NUM_PADS-1:0] gpio;
   } io_cfg_t;

   typedef struct packed {
      logic off;
      logic fast;
   } power_cfg_t;

endpackage

`default_nettype wire

//--- cw_io_top.sv
`timescale 1ns/1ps
`default_nettype none

module cw_io_top (
   input  wire                   clk_usb,
   input  wire                   reset,
   input  cw_io_pkg::reg_addr_t  reg_addr_i,
   input  cw_io_pkg::bytecnt_t   reg_bytecnt_i,
   input  cw_io_pkg::reg_data_t  reg_data_i,
   input  wire                   reg_read_i,
   input  wire                   reg_write_i,
   output cw_io_pkg::reg_data_t  reg_data_o,
   input  wire                   trigger_nrst_i,
   input  wire [3:0]             trigger_io_i,
   input  wire                   trigger_advio_i,
   input  wire                   trigger_sad_i,
   input  wire                   trigger_decoded_i,
   output wire                   trigger_ext_o,
   output wire                   trigger_o,
   input  wire                   usbio_hs2_i,
   input  wire                   target_hs1_i,
   input  wire                   pll_clk_i,
   input  wire                   glitch_clk_i,
   input  wire                   uart_tx_i,
   input  wire                   usi_out_i,
   output wire                   uart_rx_o,
   output wire                   usi_in_o,
   inout  wire [3:0]             targetio_io,   // Target GPIO1..4
   inout  wire                   target_hs2_io,
   output wire                   extclk_o,
   output wire                   hsglitch_a_o,
   output wire                   hsglitch_b_o,
   output wire                   avr_prog_en_o,
   output wire                   nrst_oe_o,
   output wire                   nrst_o,
   output wire                   pdid_oe_o,
   output wire                   pdid_o,
   output wire                   pdic_oe_o,
   output wire                   pdic_o,
   output wire                   targetpower_off_o
);

   cw_io_pkg::clk_cfg_t   clk_cfg;
   cw_io_pkg::trig_cfg_t  trig_cfg;
   cw_io_pkg::io_cfg_t    io_cfg;
   cw_io_pkg::power_cfg_t power_cfg;
   wire                   pads_highz;
   wire [3:0]             pad_out;
   wire [3:0]             pad_oe;
   wire                   hs2_out;
   wire                   hs2_oe;

   cw_reg_file i_cw_reg_file (
      .clk_usb, .reset, .reg_addr_i, .reg_bytecnt_i, .reg_data_i, .reg_read_i,
      .reg_write_i, .pad_level_i(targetio_io), .reg_data_o, .clk_cfg_o(clk_cfg),
      .trig_cfg_o(trig_cfg), .io_cfg_o(io_cfg), .power_cfg_o(power_cfg)
   );

   cw_trigger_route i_cw_trigger_route (
      .trig_cfg_i(trig_cfg), .trigger_nrst_i, .trigger_io_i, .trigger_advio_i,
      .trigger_sad_i, .trigger_decoded_i, .trigger_ext_o, .trigger_o
   );

   cw_target_io i_cw_target_io (
      .clk_cfg_i(clk_cfg), .io_cfg_i(io_cfg), .pads_highz_i(pads_highz),
      .pad_level_i(targetio_io), .uart_tx_i, .usi_out_i, .usbio_hs2_i, .target_hs1_i,
      .pll_clk_i, .glitch_clk_i, .pad_out_o(pad_out), .pad_oe_o(pad_oe), .uart_rx_o,
      .usi_in_o, .extclk_o, .target_hs2_o(hs2_out), .target_hs2_oe_o(hs2_oe),
      .hsglitch_a_o, .hsglitch_b_o, .avr_prog_en_o, .nrst_oe_o, .nrst_o,
      .pdid_oe_o, .pdid_o, .pdic_oe_o, .pdic_o
   );

   cw_power_ctrl i_cw_power_ctrl (
      .clk_usb, .reset, .power_cfg_i(power_cfg), .targetpower_off_o,
      .pads_highz_o(pads_highz)
   );

   // Pad tri-states
   for (genvar i = 0; i < cw_io_pkg::NUM_PADS; i++) begin : g_pad
      assign targetio_io[i] = pad_oe[i] ? pad_out[i] : 1'bz;
   end

   assign target_hs2_io = hs2_oe ? hs2_out : 1'bz;   // Rear clock out

endmodule

`default_nettype wire

//--- cw_power_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cw_power_ctrl (
   input  wire                    clk_usb,
   input  wire                    reset,
   input  cw_io_pkg::power_cfg_t  power_cfg_i,
   output logic                   targetpower_off_o,
   output logic                   pads_highz_o
);

   logic                               off_q1;    // First stage
   logic                               off_q2;    // Delayed copy for edge detect
   logic                               off_fall;  // Power switched back on
   logic [cw_io_pkg::PWM_PERIOD_W-1:0] pwm_cnt;
   logic [cw_io_pkg::STEP_W-1:0]       step_cnt;  // Periods into the ramp
   logic                               pwm_off;
   cw_io_pkg::power_state_e            state;

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         off_q1 <= 1'b0;
         off_q2 <= 1'b0;
      end else begin
         off_q1 <= power_cfg_i.off;
         off_q2 <= off_q1;
      end
   end

   assign off_fall = off_q2 & ~off_q1;

   // Free-running PWM timebase
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         pwm_cnt <= '0;
      end else begin
         pwm_cnt <= pwm_cnt + 1'b1;
      end
   end

   assign pwm_off = (pwm_cnt < cw_io_pkg::PWM_PERIOD_W'(cw_io_pkg::PWM_OFF_CYCLES));

   // Soft-start sequencing
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         state    <= cw_io_pkg::PWR_ON;
         step_cnt <= '0;
      end else begin
         case (state)
            cw_io_pkg::PWR_OFF: begin
               step_cnt <= '0;
               if (off_fall) begin
                  state <= power_cfg_i.fast ? cw_io_pkg::PWR_ON : cw_io_pkg::PWR_RAMP;
               end
            end
            cw_io_pkg::PWR_RAMP: begin
               if (off_q1) begin
                  state <= cw_io_pkg::PWR_OFF;   // Abort ramp
               end else if (pwm_cnt == '0) begin
                  if (step_cnt == cw_io_pkg::STEP_W'(cw_io_pkg::SOFT_STEPS - 1)) begin
                     state <= cw_io_pkg::PWR_ON;
                  end
                  step_cnt <= step_cnt + 1'b1;
               end
            end
            default: begin
               if (off_q1) begin
                  state <= cw_io_pkg::PWR_OFF;
               end
            end
         endcase
      end
   end

   // Off immediately, PWM only while ramping in slow mode
   assign targetpower_off_o = off_q1 |
                              ((state == cw_io_pkg::PWR_RAMP) & ~power_cfg_i.fast & pwm_off);
   assign pads_highz_o      = off_q1;

endmodule

`default_nettype wire

//--- cw_reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module cw_reg_file (
   input  wire                    clk_usb,
   input  wire                    reset,
   input  cw_io_pkg::reg_addr_t   reg_addr_i,
   input  cw_io_pkg::bytecnt_t    reg_bytecnt_i,
   input  cw_io_pkg::reg_data_t   reg_data_i,
   input  wire                    reg_read_i,
   input  wire                    reg_write_i,
   input  wire [3:0]              pad_level_i,   // Resolved pad levels
   output cw_io_pkg::reg_data_t   reg_data_o,
   output cw_io_pkg::clk_cfg_t    clk_cfg_o,
   output cw_io_pkg::trig_cfg_t   trig_cfg_o,
   output cw_io_pkg::io_cfg_t     io_cfg_o,
   output cw_io_pkg::power_cfg_t  power_cfg_o
);

   cw_io_pkg::reg_data_t extclk_q;
   cw_io_pkg::reg_data_t trigsrc_q;
   cw_io_pkg::reg_data_t trigmod_q;
   cw_io_pkg::reg_data_t ioroute_q [cw_io_pkg::IOROUTE_BYTES];
   logic [3:0]           ioread_q;   // Pad snapshot

   logic                                   byte_ok;   // Byte count inside IOROUTE
   logic [cw_io_pkg::IOROUTE_IDX_W-1:0]    byte_idx;

   assign byte_ok  = (reg_bytecnt_i < cw_io_pkg::bytecnt_t'(cw_io_pkg::IOROUTE_BYTES));
   assign byte_idx = reg_bytecnt_i[cw_io_pkg::IOROUTE_IDX_W-1:0];

   // Configuration writes
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         extclk_q  <= cw_io_pkg::RST_EXTCLK;
         trigsrc_q <= cw_io_pkg::RST_TRIGSRC;
         trigmod_q <= cw_io_pkg::RST_TRIGMOD;
         for (int i = 0; i < cw_io_pkg::IOROUTE_BYTES; i++) begin
            ioroute_q[i] <= cw_io_pkg::RST_IOROUTE[i*8 +: 8];
         end
      end else if (reg_write_i) begin
         case (reg_addr_i)
            cw_io_pkg::ADDR_EXTCLK:  extclk_q  <= reg_data_i;
            cw_io_pkg::ADDR_TRIGSRC: trigsrc_q <= reg_data_i;
            cw_io_pkg::ADDR_TRIGMOD: trigmod_q <= reg_data_i;
            cw_io_pkg::ADDR_IOROUTE: begin
               if (byte_ok) begin
                  ioroute_q[byte_idx] <= reg_data_i; // Larger counts dropped
               end
            end
            default: ;
         endcase
      end
   end

   // Pads sampled every cycle
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         ioread_q <= '0;
      end else begin
         ioread_q <= pad_level_i;
      end
   end

   // Registered readback, zero when no strobe
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         reg_data_o <= '0;
      end else if (reg_read_i) begin
         case (reg_addr_i)
            cw_io_pkg::ADDR_EXTCLK:  reg_data_o <= extclk_q;
            cw_io_pkg::ADDR_TRIGSRC: reg_data_o <= trigsrc_q;
            cw_io_pkg::ADDR_TRIGMOD: reg_data_o <= trigmod_q;
            cw_io_pkg::ADDR_IOROUTE: reg_data_o <= byte_ok ? ioroute_q[byte_idx] : '0;
            cw_io_pkg::ADDR_IOREAD:  reg_data_o <= {4'h0, ioread_q};
            default:                 reg_data_o <= '0;   // Unmapped
         endcase
      end else begin
         reg_data_o <= '0;
      end
   end

   // Unpack stored bytes
   assign clk_cfg_o  = cw_io_pkg::clk_cfg_t'(extclk_q);
   assign trig_cfg_o = cw_io_pkg::trig_cfg_t'({trigsrc_q, trigmod_q});

   // Byte 6 pin controls, byte 5 bit 0 AVR enable, byte 4 glitch, bytes 3..0 pads
   assign io_cfg_o = cw_io_pkg::io_cfg_t'({2'b00, ioroute_q[6][5:0],
                                           5'b00000, ioroute_q[5][0], ioroute_q[4][1:0],
                                           ioroute_q[3], ioroute_q[2],
                                           ioroute_q[1], ioroute_q[0]});

   // Byte 5 bit 1 power off, bit 2 fast switch; smart-card bits only stored
   assign power_cfg_o = cw_io_pkg::power_cfg_t'({ioroute_q[5][1], ioroute_q[5][2]});

endmodule

`default_nettype wire

//--- cw_target_io.sv
`timescale 1ns/1ps
`default_nettype none

module cw_target_io (
   input  cw_io_pkg::clk_cfg_t  clk_cfg_i,
   input  cw_io_pkg::io_cfg_t   io_cfg_i,
   input  wire                  pads_highz_i,    // Target unpowered
   input  wire [3:0]            pad_level_i,
   input  wire                  uart_tx_i,
   input  wire                  usi_out_i,
   input  wire                  usbio_hs2_i,     // AUX MCX
   input  wire                  target_hs1_i,
   input  wire                  pll_clk_i,
   input  wire                  glitch_clk_i,
   output logic [3:0]           pad_out_o,
   output logic [3:0]           pad_oe_o,
   output logic                 uart_rx_o,
   output logic                 usi_in_o,
   output logic                 extclk_o,
   output logic                 target_hs2_o,
   output logic                 target_hs2_oe_o,
   output logic                 hsglitch_a_o,
   output logic                 hsglitch_b_o,
   output logic                 avr_prog_en_o,
   output logic                 nrst_oe_o,
   output logic                 nrst_o,
   output logic                 pdid_oe_o,
   output logic                 pdid_o,
   output logic                 pdic_oe_o,
   output logic                 pdic_o
);

   // Pad drivers, first match wins
   always_comb begin
      for (int i = 0; i < cw_io_pkg::NUM_PADS; i++) begin
         pad_out_o[i] = 1'b0;
         pad_oe_o[i]  = 1'b0;
         if (!pads_highz_i) begin
            if (io_cfg_i.gpio[i].tx) begin
               pad_oe_o[i]  = 1'b1;
               pad_out_o[i] = uart_tx_i;
            end else if (io_cfg_i.gpio[i].usio) begin
               pad_oe_o[i]  = 1'b1;
               pad_out_o[i] = usi_out_i;
            end else if (i == cw_io_pkg::PAD_OC && io_cfg_i.gpio[i].usoc) begin
               pad_oe_o[i] = ~usi_out_i;   // Pull low or let go
            end else if (i == cw_io_pkg::PAD_OC && io_cfg_i.gpio[i].txo) begin
               pad_oe_o[i] = ~uart_tx_i;
            end else if (io_cfg_i.gpio[i].gpio_en) begin
               pad_oe_o[i]  = 1'b1;
               pad_out_o[i] = io_cfg_i.gpio[i].gpio_val;
            end
         end
      end
   end

   // Receive paths, lowest pad has priority
   always_comb begin
      uart_rx_o = 1'b1;   // Idle high
      usi_in_o  = 1'b1;
      for (int i = cw_io_pkg::NUM_PADS - 1; i >= 0; i--) begin
         if (io_cfg_i.gpio[i].rx) begin
            uart_rx_o = pad_level_i[i];
         end
         if (io_cfg_i.gpio[i].usii) begin
            usi_in_o = pad_level_i[i];
         end
      end
   end

   // External clock input mux, plain fabric
   always_comb begin
      case (clk_cfg_i.extclk_sel)
         cw_io_pkg::EXT_AUX: extclk_o = usbio_hs2_i;
         cw_io_pkg::EXT_HS1: extclk_o = target_hs1_i;
         default:            extclk_o = 1'b0;
      endcase
   end

   // Rear clock out
   assign target_hs2_o    = clk_cfg_i.rear_src_glitch ? glitch_clk_i : pll_clk_i;
   assign target_hs2_oe_o = clk_cfg_i.rear_en & ~pads_highz_i;

   assign hsglitch_a_o = io_cfg_i.glitch_a & glitch_clk_i;   // Gated glitch clock
   assign hsglitch_b_o = io_cfg_i.glitch_b & glitch_clk_i;

   assign avr_prog_en_o = io_cfg_i.avr_en;

   // Programming pins used as plain GPIO
   assign nrst_oe_o = io_cfg_i.nrst_en;
   assign nrst_o    = io_cfg_i.nrst_val;
   assign pdid_oe_o = io_cfg_i.pdid_en;
   assign pdid_o    = io_cfg_i.pdid_val;
   assign pdic_oe_o = io_cfg_i.pdic_en;
   assign pdic_o    = io_cfg_i.pdic_val;

endmodule

`default_nettype wire

//--- cw_trigger_route.sv
`timescale 1ns/1ps
`default_nettype none

module cw_trigger_route (
   input  cw_io_pkg::trig_cfg_t  trig_cfg_i,
   input  wire                   trigger_nrst_i,
   input  wire [3:0]             trigger_io_i,
   input  wire                   trigger_advio_i,
   input  wire                   trigger_sad_i,
   input  wire                   trigger_decoded_i,
   output logic                  trigger_ext_o,   // Combined external lines
   output logic                  trigger_o        // To capture system
);

   logic [4:0] line_en;
   logic [4:0] lines;
   logic       trig_or;
   logic       trig_and;

   assign line_en = {trig_cfg_i.en_io4, trig_cfg_i.en_io3, trig_cfg_i.en_io2,
                     trig_cfg_i.en_io1, trig_cfg_i.en_nrst};
   assign lines   = {trigger_io_i, trigger_nrst_i};

   assign trig_or  = |(line_en & lines);
   assign trig_and = &(~line_en | lines);   // Disabled lines read as 1

   always_comb begin
      case (trig_cfg_i.combine)
         cw_io_pkg::COMB_OR:   trigger_ext_o = trig_or;
         cw_io_pkg::COMB_AND:  trigger_ext_o = trig_and;
         cw_io_pkg::COMB_NAND: trigger_ext_o = ~trig_and;
         default:              trigger_ext_o = 1'b0;
      endcase
   end

   // Trigger module select
   always_comb begin
      case (trig_cfg_i.trig_mod)
         cw_io_pkg::TMOD_EDGE:    trigger_o = trigger_ext_o;
         cw_io_pkg::TMOD_ADVIO:   trigger_o = trigger_advio_i;
         cw_io_pkg::TMOD_SAD:     trigger_o = trigger_sad_i;
         cw_io_pkg::TMOD_DECODED: trigger_o = trigger_decoded_i;
         default:                 trigger_o = 1'b0;
      endcase
   end

endmodule

`default_nettype wire

//--- tb_cw_io_tasks.svh
`ifndef TB_CW_IO_TASKS_SVH
`define TB_CW_IO_TASKS_SVH

// Move to the drive point just after the n-th next rising edge
task automatic step_cycles(input int n);
   repeat (n) @(posedge clk_usb);
   #(DRIVE_DLY);
endtask

task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
   checks++;
   assert (act === exp) else begin
      $display("[FAIL] %0t ns %s expected %0h got %0h", $time, name, exp, act);
      errors++;
   end
endtask

task automatic report_test(input string name, input int errs_before);
   tests++;
   if (errors == errs_before) begin
      $display("test %s: ok", name);
   end else begin
      $display("test %s: %0d errors", name, errors - errs_before);
   end
endtask

task automatic write_reg(input cw_io_pkg::reg_addr_t addr, input cw_io_pkg::bytecnt_t cnt,
                         input cw_io_pkg::reg_data_t data);
   reg_addr_i    = addr;
   reg_bytecnt_i = cnt;
   reg_data_i    = data;
   reg_write_i   = 1'b1;   // One-cycle strobe
   step_cycles(1);
   reg_write_i   = 1'b0;
endtask

// Strobe for one cycle, data is on the bus right after that edge
task automatic read_expect(input cw_io_pkg::reg_addr_t addr, input cw_io_pkg::bytecnt_t cnt,
                           input cw_io_pkg::reg_data_t exp, input string name);
   reg_addr_i    = addr;
   reg_bytecnt_i = cnt;
   reg_read_i    = 1'b1;
   step_cycles(1);
   reg_read_i    = 1'b0;
   check_value(name, exp, reg_data_o);
endtask

task automatic write_route(input int idx, input cw_io_pkg::reg_data_t val);
   write_reg(cw_io_pkg::ADDR_IOROUTE, cw_io_pkg::bytecnt_t'(idx), val);
   route[idx] = val;   // Mirror
endtask

// Combined external trigger from the TRIGSRC byte
function automatic logic trig_ext_model(input logic [7:0] src, input logic nrst,
                                        input logic [3:0] io);
   logic [4:0] lines;
   logic       any_hi;
   logic       all_hi;
   lines  = {io, nrst};
   any_hi = 1'b0;
   all_hi = 1'b1;
   for (int i = 0; i < 5; i++) begin
      if (src[i+1]) begin   // Enables in bits 5..1
         any_hi = any_hi | lines[i];
         all_hi = all_hi & lines[i];
      end
   end
   case (src[7:6])
      2'd0:    return any_hi;
      2'd1:    return all_hi;
      2'd2:    return !all_hi;
      default: return 1'b0;
   endcase
endfunction

// Returns {drive enable, drive value} for one pad
function automatic logic [1:0] pad_drive_model(input logic [7:0] cfg, input int idx,
                                               input logic tx, input logic usi);
   if (cfg[0]) return {1'b1, tx};
   if (cfg[2]) return {1'b1, usi};
   if (idx == 2 && cfg[4]) return usi ? 2'b00 : 2'b10;   // Open collector, low only
   if (idx == 2 && cfg[5]) return tx ? 2'b00 : 2'b10;
   if (cfg[7]) return {1'b1, cfg[6]};
   return 2'b00;
endfunction

function automatic logic [3:0] pad_levels_model();
   logic [1:0] drv;
   logic [3:0] lvl;
   for (int i = 0; i < 4; i++) begin
      drv    = pad_drive_model(route[i], i, uart_tx_i, usi_out_i);
      lvl[i] = drv[1] ? drv[0] : (pad_drv_en[i] ? pad_drv_val[i] : 1'b1);   // Pull-up
   end
   return lvl;
endfunction

// First selected pad wins, idle high
function automatic logic rx_model(input int sel_bit, input logic [3:0] lvl);
   for (int i = 0; i < 4; i++) begin
      if (route[i][sel_bit]) return lvl[i];
   end
   return 1'b1;
endfunction

`endif

//--- tb_cw_io_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cw_io_top;

   localparam int CLK_PERIOD  = 100;
   localparam int DRIVE_DLY   = 10;
   localparam int PWM_LEN     = 1 << cw_io_pkg::PWM_PERIOD_W;
   localparam int RAMP_WIN    = (cw_io_pkg::SOFT_STEPS + 3) * PWM_LEN;   // Ramp plus settling
   localparam int RUN_CYCLES  = 600 + 40 * 3 + 40 * 5 + 12 * 7 + 24 * 5 + RAMP_WIN;
   localparam int WATCHDOG_NS = 2 * RUN_CYCLES * CLK_PERIOD;

   logic                 clk_usb;
   logic                 reset;
   cw_io_pkg::reg_addr_t reg_addr_i;
   cw_io_pkg::bytecnt_t  reg_bytecnt_i;
   cw_io_pkg::reg_data_t reg_data_i;
   logic                 reg_read_i;
   logic                 reg_write_i;
   cw_io_pkg::reg_data_t reg_data_o;
   logic                 trigger_nrst_i;
   logic [3:0]           trigger_io_i;
   logic                 trigger_advio_i;
   logic                 trigger_sad_i;
   logic                 trigger_decoded_i;
   wire                  trigger_ext_o;
   wire                  trigger_o;
   logic                 usbio_hs2_i;
   logic                 target_hs1_i;
   logic                 pll_clk_i;
   logic                 glitch_clk_i;
   logic                 uart_tx_i;
   logic                 usi_out_i;
   wire                  uart_rx_o;
   wire                  usi_in_o;
   wire  [3:0]           targetio_io;
   wire                  target_hs2_io;
   wire                  extclk_o;
   wire                  hsglitch_a_o;
   wire                  hsglitch_b_o;
   wire                  avr_prog_en_o;
   wire                  nrst_oe_o;
   wire                  nrst_o;
   wire                  pdid_oe_o;
   wire                  pdid_o;
   wire                  pdic_oe_o;
   wire                  pdic_o;
   wire                  targetpower_off_o;

   int          errors;
   int          checks;
   int          tests;
   int unsigned seed;
   logic [3:0]  pad_drv_en;    // Target side drivers
   logic [3:0]  pad_drv_val;
   logic [7:0]  route [8];     // IOROUTE as last written
   logic        prev_rd;

   `include "tb_cw_io_tasks.svh"

   cw_io_top i_cw_io_top (.*);

   // Target pads: pull-up plus a driver that only acts on a released pad
   for (genvar i = 0; i < 4; i++) begin : g_pad_model
      pullup pu (targetio_io[i]);
      assign targetio_io[i] = (pad_drv_en[i] && !i_cw_io_top.pad_oe[i]) ? pad_drv_val[i] : 1'bz;
   end

   initial begin
      clk_usb = 1'b0;
      forever #(CLK_PERIOD / 2) clk_usb = ~clk_usb;
   end

   // Read data must be zero after a cycle without strobe
   always @(negedge clk_usb) begin
      if (!reset && !prev_rd) begin
         check_value("reg_data_o idle", 0, reg_data_o);
      end
      prev_rd = reg_read_i;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns, test sequence did not finish", WATCHDOG_NS);
      $display("TB FAILED");
      $finish;
   end

   task automatic restore_defaults();
      write_reg(cw_io_pkg::ADDR_EXTCLK, 0, cw_io_pkg::RST_EXTCLK);
      write_reg(cw_io_pkg::ADDR_TRIGSRC, 0, cw_io_pkg::RST_TRIGSRC);
      write_reg(cw_io_pkg::ADDR_TRIGMOD, 0, cw_io_pkg::RST_TRIGMOD);
      for (int i = 0; i < cw_io_pkg::IOROUTE_BYTES; i++) begin
         write_route(i, (i == 5) ? 8'h04 : cw_io_pkg::RST_IOROUTE[i*8 +: 8]);   // Fast, on
      end
      pad_drv_en = 4'h0;
   endtask

   task automatic register_map_sweep();
      int         errs0;
      logic [7:0] ext;
      logic [7:0] src;
      logic [7:0] tmod;
      errs0 = errors;
      read_expect(cw_io_pkg::ADDR_EXTCLK, 0, cw_io_pkg::RST_EXTCLK, "EXTCLK reset");
      read_expect(cw_io_pkg::ADDR_TRIGSRC, 0, cw_io_pkg::RST_TRIGSRC, "TRIGSRC reset");
      read_expect(cw_io_pkg::ADDR_TRIGMOD, 0, cw_io_pkg::RST_TRIGMOD, "TRIGMOD reset");
      for (int i = 0; i < 8; i++) begin
         read_expect(cw_io_pkg::ADDR_IOROUTE, i, route[i], $sformatf("IOROUTE[%0d] reset", i));
      end
      read_expect(8'h10, 0, 8'h00, "unmapped 0x10");
      read_expect(8'hFF, 0, 8'h00, "unmapped 0xFF");
      ext  = 8'($urandom);
      src  = 8'($urandom);
      tmod = 8'($urandom);
      write_reg(cw_io_pkg::ADDR_EXTCLK, 0, ext);
      write_reg(cw_io_pkg::ADDR_TRIGSRC, 0, src);
      write_reg(cw_io_pkg::ADDR_TRIGMOD, 0, tmod);
      read_expect(cw_io_pkg::ADDR_EXTCLK, 0, ext, "EXTCLK");
      read_expect(cw_io_pkg::ADDR_TRIGSRC, 0, src, "TRIGSRC");
      read_expect(cw_io_pkg::ADDR_TRIGMOD, 0, tmod, "TRIGMOD");
      for (int i = 0; i < 8; i++) begin
         write_route(i, 8'($urandom));
      end
      write_reg(cw_io_pkg::ADDR_IOROUTE, 8, 8'hA5);    // Out of range, dropped
      write_reg(cw_io_pkg::ADDR_IOROUTE, 77, 8'h5A);
      for (int i = 0; i < 8; i++) begin
         read_expect(cw_io_pkg::ADDR_IOROUTE, i, route[i], $sformatf("IOROUTE[%0d]", i));
      end
      read_expect(cw_io_pkg::ADDR_IOROUTE, 8, 8'h00, "IOROUTE[8]");
      restore_defaults();
      report_test("register map", errs0);
   endtask

   task automatic trigger_path_random();
      int         errs0;
      logic [7:0] src;
      logic [7:0] tmod;
      logic       exp_ext;
      logic       exp_trig;
      errs0 = errors;
      for (int n = 0; n < 40; n++) begin
         src  = 8'($urandom);
         tmod = 8'($urandom);
         write_reg(cw_io_pkg::ADDR_TRIGSRC, 0, src);
         write_reg(cw_io_pkg::ADDR_TRIGMOD, 0, tmod);
         {trigger_io_i, trigger_nrst_i, trigger_advio_i, trigger_sad_i, trigger_decoded_i} =
            8'($urandom);
         step_cycles(1);
         exp_ext = trig_ext_model(src, trigger_nrst_i, trigger_io_i);
         case (tmod[2:0])
            3'd0:    exp_trig = exp_ext;
            3'd1:    exp_trig = trigger_advio_i;
            3'd2:    exp_trig = trigger_sad_i;
            3'd3:    exp_trig = trigger_decoded_i;
            default: exp_trig = 1'b0;   // Unused module codes
         endcase
         check_value("trigger_ext_o", exp_ext, trigger_ext_o);
         check_value("trigger_o", exp_trig, trigger_o);
      end
      restore_defaults();
      report_test("trigger path", errs0);
   endtask

   // Random pad routing, optional IOREAD check after the pads have settled
   task automatic pad_routing_random(input int iters, input bit readback);
      int         errs0;
      logic [3:0] lvl;
      errs0 = errors;
      for (int n = 0; n < iters; n++) begin
         for (int i = 0; i < 4; i++) begin
            write_route(i, 8'($urandom));
         end
         {uart_tx_i, usi_out_i} = 2'($urandom);
         pad_drv_en  = 4'($urandom);
         pad_drv_val = 4'($urandom);
         step_cycles(readback ? 2 : 1);
         lvl = pad_levels_model();
         if (readback) begin
            read_expect(cw_io_pkg::ADDR_IOREAD, 0, {4'h0, lvl}, "IOREAD");
         end else begin
            for (int i = 0; i < 4; i++) begin
               check_value($sformatf("targetio_io[%0d]", i), lvl[i], targetio_io[i]);
            end
            check_value("uart_rx_o", rx_model(1, lvl), uart_rx_o);
            check_value("usi_in_o", rx_model(3, lvl), usi_in_o);
         end
      end
      restore_defaults();
      report_test(readback ? "pad readback" : "pad routing", errs0);
   endtask

   task automatic power_sequencing();
      int   errs0;
      int   full;
      int   longer;
      int   run;
      int   last_high;
      logic seen_low;
      errs0 = errors;
      for (int i = 0; i < 4; i++) begin
         write_route(i, 8'h80);   // GPIO drive low on every pad
      end
      write_reg(cw_io_pkg::ADDR_EXTCLK, 0, 8'h43);   // Rear clock on
      write_route(5, 8'h06);                          // Off, fast
      check_value("targetpower_off_o", 0, targetpower_off_o);
      step_cycles(1);
      check_value("targetpower_off_o", 1, targetpower_off_o);
      check_value("targetio_io", 4'hF, targetio_io);   // Released, pulled up
      check_value("target_hs2_io", 1'bz, target_hs2_io);
      write_route(5, 8'h04);
      check_value("targetpower_off_o", 1, targetpower_off_o);
      step_cycles(1);
      check_value("targetpower_off_o", 0, targetpower_off_o);
      check_value("targetio_io", 4'h0, targetio_io);
      // Slow mode: off, then on through the PWM ramp
      write_route(5, 8'h02);
      step_cycles(4);
      write_route(5, 8'h00);
      full      = 0;
      longer    = 0;
      run       = 0;
      last_high = -1;
      seen_low  = 1'b0;
      for (int c = 0; c < RAMP_WIN; c++) begin
         if (targetpower_off_o) begin
            run++;
            last_high = c;
         end else begin
            if (seen_low && run == cw_io_pkg::PWM_OFF_CYCLES) full++;
            if (seen_low && run > cw_io_pkg::PWM_OFF_CYCLES) longer++;
            seen_low = 1'b1;   // Off phase before the ramp not counted
            run      = 0;
         end
         step_cycles(1);
      end
      check_value("full PWM off periods", cw_io_pkg::SOFT_STEPS - 1, full);
      check_value("over-long PWM off periods", 0, longer);
      check_value("ramp ended in time", 1,
                  last_high <= (cw_io_pkg::SOFT_STEPS + 1) * PWM_LEN);
      check_value("targetpower_off_o settled", 0, targetpower_off_o);
      restore_defaults();
      report_test("target power", errs0);
   endtask

   task automatic clock_glitch_routing();
      int         errs0;
      logic [7:0] ext;
      logic [7:0] glit;
      logic [7:0] misc;
      logic [7:0] pins;
      logic       exp_clk;
      logic       exp_rear;
      errs0 = errors;
      for (int n = 0; n < 24; n++) begin
         ext  = 8'($urandom);
         glit = 8'($urandom);
         misc = (8'($urandom) & 8'hF9) | 8'h04;   // Power stays on
         pins = 8'($urandom);
         if (n % 3 == 0) ext[2:0] = 3'd0;
         if (n % 3 == 1) ext[2:0] = 3'd3;
         write_reg(cw_io_pkg::ADDR_EXTCLK, 0, ext);
         write_route(4, glit);
         write_route(5, misc);
         write_route(6, pins);
         {usbio_hs2_i, target_hs1_i, pll_clk_i, glitch_clk_i} = 4'($urandom);
         step_cycles(1);
         case (ext[2:0])
            3'd0:    exp_clk = usbio_hs2_i;
            3'd3:    exp_clk = target_hs1_i;
            default: exp_clk = 1'b0;
         endcase
         exp_rear = ext[5] ? glitch_clk_i : pll_clk_i;
         check_value("extclk_o", exp_clk, extclk_o);
         check_value("target_hs2_io", ext[6] ? exp_rear : 1'bz, target_hs2_io);
         check_value("hsglitch_a_o", glit[0] & glitch_clk_i, hsglitch_a_o);
         check_value("hsglitch_b_o", glit[1] & glitch_clk_i, hsglitch_b_o);
         check_value("avr_prog_en_o", misc[0], avr_prog_en_o);
         check_value("nrst/pdid/pdic pins", pins[5:0],
                     {pdic_o, pdic_oe_o, pdid_o, pdid_oe_o, nrst_o, nrst_oe_o});
      end
      restore_defaults();
      report_test("clock and glitch routing", errs0);
   endtask

   initial begin
      errors  = 0;
      checks  = 0;
      tests   = 0;
      prev_rd = 1'b0;
      seed    = 32'h8a23;
      seed    = $urandom(seed);   // Seed once
      reset             = 1'b1;
      reg_addr_i        = '0;
      reg_bytecnt_i     = '0;
      reg_data_i        = '0;
      reg_read_i        = 1'b0;
      reg_write_i       = 1'b0;
      trigger_nrst_i    = 1'b0;
      trigger_io_i      = 4'h0;
      trigger_advio_i   = 1'b0;
      trigger_sad_i     = 1'b0;
      trigger_decoded_i = 1'b0;
      usbio_hs2_i       = 1'b0;
      target_hs1_i      = 1'b0;
      pll_clk_i         = 1'b0;
      glitch_clk_i      = 1'b0;
      uart_tx_i         = 1'b1;
      usi_out_i         = 1'b1;
      pad_drv_en        = 4'h0;
      pad_drv_val       = 4'h0;
      for (int i = 0; i < 8; i++) begin
         route[i] = cw_io_pkg::RST_IOROUTE[i*8 +: 8];
      end
      repeat (8) @(posedge clk_usb);
      #(DRIVE_DLY);
      reset = 1'b0;
      step_cycles(1);
      register_map_sweep();
      trigger_path_random();
      pad_routing_random(40, 1'b0);
      pad_routing_random(12, 1'b1);
      power_sequencing();
      clock_glitch_routing();
      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
